//--- verilog/ipod_pkg.sv
`default_nettype none

package ipod_pkg;

  // ====================
  // Widths
  // ====================
  localparam int ADDR_W   = 23;  // Flash word address
  localparam int WORD_W   = 32;  // One flash word holds two samples
  localparam int SAMPLE_W = 16;

  // Keyboard character, already decoded to ASCII
  typedef logic [7:0] ascii_t;

  // ====================
  // Commands and states
  // ====================
  typedef enum logic [2:0] {cmd_none, cmd_play, cmd_stop, cmd_fwd, cmd_back, cmd_rewind} cmd_t;

  typedef enum logic {st_idle, st_play} play_state_t;

  // Word fetcher FSM
  typedef enum logic [1:0] {
    fs_wait_tick,
    fs_request,
    fs_response,
    fs_second_half
  } fetch_state_t;

endpackage

`default_nettype wire

//--- verilog/flash_read_if.sv
`timescale 1ns/1ps
`default_nettype none

interface flash_read_if;

  logic                          req_valid;  // Held until accepted
  logic [ipod_pkg::ADDR_W-1:0]   req_addr;
  logic                          req_ready;
  logic                          rsp_valid;  // Single cycle, no back-pressure
  logic [ipod_pkg::WORD_W-1:0]   rsp_data;

  // Fetcher side issues requests and takes responses
  modport fetcher (
    output req_valid, req_addr,
    input  req_ready, rsp_valid, rsp_data
  );

  modport port (
    input  req_valid, req_addr,
    output req_ready, rsp_valid, rsp_data
  );

endinterface

`default_nettype wire

//--- verilog/key_command_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module key_command_decoder (
  input  wire                     clk,
  input  wire                     reset,
  input  wire ipod_pkg::ascii_t   kbd_ascii,
  input  wire                     kbd_valid,
  output ipod_pkg::cmd_t          cmd,
  output logic                    cmd_valid
);

  ipod_pkg::cmd_t decoded;

  // Both cases of each command letter
  always_comb
  begin
    case (kbd_ascii)
      8'h45, 8'h65: decoded = ipod_pkg::cmd_play;    // E e
      8'h44, 8'h64: decoded = ipod_pkg::cmd_stop;    // D d
      8'h42, 8'h62: decoded = ipod_pkg::cmd_back;    // B b
      8'h46, 8'h66: decoded = ipod_pkg::cmd_fwd;     // F f
      8'h52, 8'h72: decoded = ipod_pkg::cmd_rewind;  // R r
      default:      decoded = ipod_pkg::cmd_none;
    endcase
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      cmd       <= ipod_pkg::cmd_none;
      cmd_valid <= 1'b0;
    end
    else
    begin
      cmd_valid <= kbd_valid && (decoded != ipod_pkg::cmd_none);
      if (kbd_valid)
        cmd <= decoded;
    end
  end

endmodule

`default_nettype wire

//--- verilog/address_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module address_sequencer #(
  parameter int LAST_WORD = 524287
) (
  input  wire                           clk,
  input  wire                           reset,
  input  wire ipod_pkg::cmd_t           cmd,
  input  wire                           cmd_valid,
  input  wire                           word_done,
  output logic                          playing,
  output logic                          backward,
  output logic [ipod_pkg::ADDR_W-1:0]   word_addr
);

  localparam logic [ipod_pkg::ADDR_W-1:0] LAST_ADDR = LAST_WORD[ipod_pkg::ADDR_W-1:0];

  ipod_pkg::play_state_t          state;
  logic                           hold;       // Loaded word not played yet
  logic                           rewind;
  logic [ipod_pkg::ADDR_W-1:0]    next_addr;

  assign playing = (state == ipod_pkg::st_play);
  assign rewind  = cmd_valid && (cmd == ipod_pkg::cmd_rewind);

  // Neighbour word in the current direction
  always_comb
  begin
    if (backward)
      next_addr = (word_addr == '0) ? LAST_ADDR : word_addr - 1'b1;
    else
      next_addr = (word_addr == LAST_ADDR) ? '0 : word_addr + 1'b1;
  end

  // ====================
  // Play and direction
  // ====================
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state    <= ipod_pkg::st_idle;
      backward <= 1'b0;
    end
    else if (cmd_valid)
    begin
      case (cmd)
        ipod_pkg::cmd_play: state    <= ipod_pkg::st_play;
        ipod_pkg::cmd_stop: state    <= ipod_pkg::st_idle;
        ipod_pkg::cmd_fwd:  backward <= 1'b0;  // Direction changes in any state
        ipod_pkg::cmd_back: backward <= 1'b1;
        default:            ;
      endcase
    end
  end

  // ====================
  // Word address
  // ====================
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      word_addr <= '0;
      hold      <= 1'b0;
    end
    else if (rewind)
    begin
      word_addr <= backward ? LAST_ADDR : '0;  // Start of clip for this direction
      hold      <= 1'b1;
    end
    else if (word_done)
    begin
      if (hold)
        hold <= 1'b0;  // Stay on the loaded word once
      else
        word_addr <= next_addr;
    end
  end

endmodule

`default_nettype wire

//--- verilog/word_fetcher.sv
`timescale 1ns/1ps
`default_nettype none

module word_fetcher #(
  parameter int TICK_DIV = 2273
) (
  input  wire                             clk,
  input  wire                             reset,
  input  wire                             playing,
  input  wire                             backward,
  input  wire [ipod_pkg::ADDR_W-1:0]      word_addr,
  flash_read_if.fetcher                   flash,
  output logic                            word_done,
  output logic [ipod_pkg::SAMPLE_W-1:0]   sample,
  output logic                            sample_valid
);

  localparam int CNT_W = $clog2(TICK_DIV + 1);
  localparam int HI    = ipod_pkg::WORD_W - 1;
  localparam int LO    = ipod_pkg::SAMPLE_W - 1;

  ipod_pkg::fetch_state_t         state;
  logic [CNT_W-1:0]               tick_cnt;
  logic                           tick;
  logic                           outstanding;  // Accepted read, response pending
  logic                           issue;
  logic                           first_emit;
  logic                           second_emit;
  logic [ipod_pkg::WORD_W-1:0]    word_buf;
  logic                           word_rev;     // Direction when the word arrived

  // ====================
  // Sample timer
  // ====================
  assign tick = (tick_cnt == CNT_W'(TICK_DIV - 1));

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      tick_cnt <= '0;
    else if (tick)
      tick_cnt <= '0;
    else
      tick_cnt <= tick_cnt + 1'b1;
  end

  // New read only when nothing is in flight, and never on a stale address
  assign issue = (state == ipod_pkg::fs_wait_tick) && tick && playing && !word_done &&
                 !flash.req_valid && !outstanding;
  assign first_emit  = (state == ipod_pkg::fs_response) && playing && flash.rsp_valid;
  assign second_emit = (state == ipod_pkg::fs_second_half) && playing && tick;

  // ====================
  // Flash request channel
  // ====================
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      flash.req_valid <= 1'b0;
      outstanding     <= 1'b0;
    end
    else
    begin
      if (flash.req_valid && flash.req_ready)
      begin
        flash.req_valid <= 1'b0;
        outstanding     <= 1'b1;
      end
      else if (issue)
        flash.req_valid <= 1'b1;
      if (flash.rsp_valid)
        outstanding <= 1'b0;  // Also drains a read abandoned by stop
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state        <= ipod_pkg::fs_wait_tick;
      sample_valid <= 1'b0;
      word_done    <= 1'b0;
    end
    else
    begin
      sample_valid <= first_emit || second_emit;
      word_done    <= second_emit;
      if (!playing)
        state <= ipod_pkg::fs_wait_tick;  // Drop the rest of the word
      else
      begin
        case (state)
          ipod_pkg::fs_wait_tick:   if (issue) state <= ipod_pkg::fs_request;
          ipod_pkg::fs_request:     if (flash.req_ready) state <= ipod_pkg::fs_response;
          ipod_pkg::fs_response:    if (first_emit) state <= ipod_pkg::fs_second_half;
          ipod_pkg::fs_second_half: if (second_emit) state <= ipod_pkg::fs_wait_tick;
          default:                  state <= ipod_pkg::fs_wait_tick;
        endcase
      end
    end
  end

  // Address and sample data
  always_ff @(posedge clk)
  begin
    if (issue)
      flash.req_addr <= word_addr;
    if (first_emit)
    begin
      word_buf <= flash.rsp_data;
      word_rev <= backward;
      sample   <= backward ? flash.rsp_data[LO:0] : flash.rsp_data[HI -: ipod_pkg::SAMPLE_W];
    end
    else if (second_emit)
      sample <= word_rev ? word_buf[HI -: ipod_pkg::SAMPLE_W] : word_buf[LO:0];
  end

endmodule

`default_nettype wire

//--- verilog/ipod_top.sv
`timescale 1ns/1ps
`default_nettype none

module ipod_top #(
  parameter int LAST_WORD = 524287,
  parameter int TICK_DIV  = 2273
) (
  input  wire                             clk,
  input  wire                             reset,
  input  wire ipod_pkg::ascii_t           kbd_ascii,
  input  wire                             kbd_valid,
  output logic                            flash_read,
  output logic [ipod_pkg::ADDR_W-1:0]     flash_addr,
  input  wire                             flash_waitrequest,
  input  wire [ipod_pkg::WORD_W-1:0]      flash_readdata,
  input  wire                             flash_readdatavalid,
  output logic [ipod_pkg::SAMPLE_W-1:0]   sample,
  output logic                            sample_valid,
  output logic                            playing,
  output logic                            backward
);

  ipod_pkg::cmd_t                 cmd;
  logic                           cmd_valid;
  logic [ipod_pkg::ADDR_W-1:0]    word_addr;
  logic                           word_done;

  flash_read_if flash_if ();

  // ====================
  // Flash port mapping
  // ====================
  assign flash_read         = flash_if.req_valid;
  assign flash_addr         = flash_if.req_addr;
  assign flash_if.req_ready = ~flash_waitrequest;
  assign flash_if.rsp_valid = flash_readdatavalid;
  assign flash_if.rsp_data  = flash_readdata;

  key_command_decoder decoder_i (
    .clk       (clk),
    .reset     (reset),
    .kbd_ascii (kbd_ascii),
    .kbd_valid (kbd_valid),
    .cmd       (cmd),
    .cmd_valid (cmd_valid)
  );

  address_sequencer #(.LAST_WORD(LAST_WORD)) sequencer_i (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .word_done (word_done),
    .playing   (playing),
    .backward  (backward),
    .word_addr (word_addr)
  );

  // Sample timer lives in here as a clock enable
  word_fetcher #(.TICK_DIV(TICK_DIV)) fetcher_i (
    .clk          (clk),
    .reset        (reset),
    .playing      (playing),
    .backward     (backward),
    .word_addr    (word_addr),
    .flash        (flash_if.fetcher),
    .word_done    (word_done),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

endmodule

`default_nettype wire

//--- verif/flash_model.sv
`timescale 1ns/1ps
`default_nettype none

module flash_model #(
  parameter int SEED = 41
) (
  input  wire                             clk,
  input  wire                             reset,
  input  wire                             read,
  input  wire [ipod_pkg::ADDR_W-1:0]      addr,
  output logic                            waitrequest,
  output logic [ipod_pkg::WORD_W-1:0]     readdata,
  output logic                            readdatavalid
);

  logic                           seen_read;
  logic                           accept;     // Read taken at the coming edge
  logic [ipod_pkg::ADDR_W-1:0]    seen_addr;
  logic [ipod_pkg::ADDR_W-1:0]    addr_q;
  int                             wait_cnt;   // Wait states left for the coming read
  int                             lat_cnt;

  initial
  begin
    readdata      = '0;
    readdatavalid = 1'b0;
    lat_cnt       = 0;
    addr_q        = '0;
    void'($urandom(SEED));
    wait_cnt      = $urandom_range(3, 0);
    waitrequest   = (wait_cnt != 0);
    forever
    begin
      // Look at the bus mid cycle, answer just after the edge
      @(negedge clk);
      seen_read = read;
      seen_addr = addr;
      accept    = read && !waitrequest;
      @(posedge clk);
      #1;
      readdatavalid = 1'b0;
      if (reset)
        lat_cnt = 0;
      else
      begin
        if (accept)
        begin
          addr_q      = seen_addr;
          lat_cnt     = $urandom_range(4, 1);  // Read latency
          wait_cnt    = $urandom_range(3, 0);
          waitrequest = (wait_cnt != 0);
        end
        else if (seen_read && wait_cnt > 0)
        begin
          wait_cnt    = wait_cnt - 1;
          waitrequest = (wait_cnt != 0);
        end
        // Countdown starts in the cycle of acceptance
        if (lat_cnt > 0)
        begin
          lat_cnt = lat_cnt - 1;
          if (lat_cnt == 0)
          begin
            readdatavalid = 1'b1;
            readdata      = {addr_q[15:0] + 16'h1000, addr_q[15:0] + 16'h2000};
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_ipod.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ipod;

  localparam int LAST_WORD = 15;
  localparam int TICK_DIV  = 8;

  logic                           clk;
  logic                           reset;
  ipod_pkg::ascii_t               kbd_ascii;
  logic                           kbd_valid;
  logic                           flash_read;
  logic [ipod_pkg::ADDR_W-1:0]    flash_addr;
  logic                           flash_waitrequest;
  logic [ipod_pkg::WORD_W-1:0]    flash_readdata;
  logic                           flash_readdatavalid;
  logic [ipod_pkg::SAMPLE_W-1:0]  sample;
  logic                           sample_valid;
  logic                           playing;
  logic                           backward;

  // Reference model of the player
  logic [ipod_pkg::ADDR_W-1:0]    m_addr;
  logic                           m_back;
  logic                           m_hold;
  logic                           m_half;       // Next sample is the second half
  logic                           m_word_back;  // Direction when the word started
  logic [ipod_pkg::SAMPLE_W-1:0]  expected;
  logic [ipod_pkg::SAMPLE_W-1:0]  last_sample;
  logic [ipod_pkg::ADDR_W-1:0]    resume_word;
  logic [ipod_pkg::ADDR_W-1:0]    prev_addr;
  logic                           prev_stall;
  logic [ipod_pkg::ADDR_W-1:0]    last_req;     // Address of the last transferred read
  int                             sample_count;
  int                             wraps_up;     // Seen on the flash bus
  int                             wraps_down;
  string                          cur_test;

  ipod_top #(.LAST_WORD(LAST_WORD), .TICK_DIV(TICK_DIV)) dut_i (
    .clk                 (clk),
    .reset               (reset),
    .kbd_ascii           (kbd_ascii),
    .kbd_valid           (kbd_valid),
    .flash_read          (flash_read),
    .flash_addr          (flash_addr),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .sample              (sample),
    .sample_valid        (sample_valid),
    .playing             (playing),
    .backward            (backward)
  );

  flash_model #(.SEED(41)) flash_i (
    .clk           (clk),
    .reset         (reset),
    .read          (flash_read),
    .addr          (flash_addr),
    .waitrequest   (flash_waitrequest),
    .readdata      (flash_readdata),
    .readdatavalid (flash_readdatavalid)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // ====================
  // Error reporting
  // ====================
  task automatic abort_run;
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string test, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("ERROR %s: expected 0x%0h, actual 0x%0h", test, exp, act);
    abort_run();
  endtask

  task automatic report_problem(input string what);
    $display("ERROR %s", what);
    abort_run();
  endtask

  // Flash data rule, upper half a + 0x1000 and lower half a + 0x2000
  function automatic logic [15:0] half_of(input logic [ipod_pkg::ADDR_W-1:0] a,
                                          input logic upper);
    return upper ? (a[15:0] + 16'h1000) : (a[15:0] + 16'h2000);
  endfunction

  // Word done, step or drop the hold flag
  task automatic advance_model;
    if (m_hold)
      m_hold = 1'b0;
    else if (m_back)
    begin
      if (m_addr == 0)
        m_addr = LAST_WORD;
      else
        m_addr = m_addr - 1'b1;
    end
    else if (m_addr == LAST_WORD)
      m_addr = '0;
    else
      m_addr = m_addr + 1'b1;
  endtask

  // ====================
  // Checker
  // ====================
  always @(negedge clk)
  begin
    if (!reset)
    begin
      if (sample_valid)
      begin
        if (!m_half)
        begin
          expected    = half_of(m_addr, !m_back);  // Forward starts with the upper half
          m_word_back = m_back;
        end
        else
          expected = half_of(m_addr, m_word_back);
        assert (sample === expected) else report_mismatch(cur_test, expected, sample);
        last_sample  = sample;
        sample_count = sample_count + 1;
        if (m_half)
          advance_model();
        m_half = !m_half;
      end
      if (prev_stall)
      begin
        assert (flash_read) else report_problem("flash_read dropped while waitrequest was high");
        assert (flash_addr === prev_addr)
          else report_mismatch("back-pressure", prev_addr, flash_addr);
      end
      prev_stall = flash_read && flash_waitrequest;
      prev_addr  = flash_addr;
      // Read transfers at the coming edge
      if (flash_read && !flash_waitrequest)
      begin
        if (last_req == LAST_WORD && flash_addr == '0)
          wraps_up = wraps_up + 1;
        if (last_req == '0 && flash_addr == LAST_WORD)
          wraps_down = wraps_down + 1;
        last_req = flash_addr;
      end
    end
  end

  // ====================
  // Stimulus helpers
  // ====================
  task automatic send_key(input ipod_pkg::ascii_t ch);
    kbd_ascii = ch;
    kbd_valid = 1'b1;
    @(posedge clk);
    #1;
    kbd_valid = 1'b0;
  endtask

  task automatic wait_mode(input logic exp_play, input logic exp_back);
    int cycles;
    cycles = 0;
    while (playing !== exp_play || backward !== exp_back)
    begin
      @(posedge clk);
      #1;
      cycles = cycles + 1;
      assert (cycles <= 3) else report_mismatch(cur_test, {exp_play, exp_back}, {playing, backward});
    end
  endtask

  task automatic hold_mode(input logic exp_play, input logic exp_back, input int n);
    int i;
    for (i = 0; i < n; i++)
    begin
      @(posedge clk);
      #1;
      assert (playing === exp_play && backward === exp_back)
        else report_mismatch(cur_test, {exp_play, exp_back}, {playing, backward});
    end
  endtask

  task automatic wait_samples(input int n);
    int target;
    int cycles;
    target = sample_count + n;
    cycles = 0;
    while (sample_count < target)
    begin
      @(posedge clk);
      #1;
      cycles = cycles + 1;
      assert (cycles < n * 100) else report_problem({cur_test, ": timed out waiting for samples"});
    end
  endtask

  task automatic expect_quiet(input int n);
    int i;
    for (i = 0; i < n; i++)
    begin
      @(posedge clk);
      #1;
      assert (!sample_valid) else report_problem({cur_test, ": sample appeared while stopped"});
    end
  endtask

  task automatic stop_playback;
    send_key("D");
    wait_mode(1'b0, m_back);
    expect_quiet(40);
    m_half = 1'b0;  // Rest of the word is abandoned
  endtask

  // ====================
  // Test sequence
  // ====================
  initial
  begin
    reset        = 1'b1;
    kbd_ascii    = 8'h00;
    kbd_valid    = 1'b0;
    m_addr       = '0;
    m_back       = 1'b0;
    m_hold       = 1'b0;
    m_half       = 1'b0;
    m_word_back  = 1'b0;
    sample_count = 0;
    wraps_up     = 0;
    wraps_down   = 0;
    prev_stall   = 1'b0;
    prev_addr    = '0;
    last_req     = '0;
    cur_test     = "reset";
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    for (int i = 0; i < 40; i++)
    begin
      assert (!playing && !backward && !flash_read && !sample_valid)
        else report_problem("outputs not idle after reset");
      @(posedge clk);
      #1;
    end

    cur_test = "forward play";
    send_key("e");
    wait_mode(1'b1, 1'b0);
    wait_samples(1);
    assert (last_sample === 16'h1000) else report_mismatch(cur_test, 16'h1000, last_sample);
    wait_samples(9);
    cur_test = "non-command keys";
    send_key("x");
    hold_mode(1'b1, 1'b0, 4);
    send_key("7");
    hold_mode(1'b1, 1'b0, 4);
    cur_test = "forward play";
    wait_samples(26);
    assert (wraps_up > 0) else report_problem("forward play never wrapped from 15 to 0");

    cur_test = "stop and backward";
    stop_playback();
    send_key("b");
    wait_mode(1'b0, 1'b1);
    m_back      = 1'b1;
    resume_word = m_addr;
    send_key("E");
    wait_mode(1'b1, 1'b1);
    wait_samples(1);
    expected = half_of(resume_word, 1'b0);  // Same word, lower half first
    assert (last_sample === expected) else report_mismatch(cur_test, expected, last_sample);
    wait_samples(35);
    assert (wraps_down > 0) else report_problem("backward play never wrapped from 0 to 15");

    cur_test = "rewind backward";
    stop_playback();
    send_key("x");
    hold_mode(1'b0, 1'b1, 4);
    send_key("R");
    m_addr = LAST_WORD;
    m_hold = 1'b1;
    send_key("e");
    wait_mode(1'b1, 1'b1);
    wait_samples(1);
    assert (last_sample === 16'h200F) else report_mismatch(cur_test, 16'h200F, last_sample);
    wait_samples(8);

    cur_test = "rewind forward";
    stop_playback();
    send_key("f");
    wait_mode(1'b0, 1'b0);
    m_back = 1'b0;
    send_key("r");
    m_addr = '0;
    m_hold = 1'b1;
    send_key("e");
    wait_mode(1'b1, 1'b0);
    wait_samples(1);
    assert (last_sample === 16'h1000) else report_mismatch(cur_test, 16'h1000, last_sample);
    wait_samples(8);
    stop_playback();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
verilog/ipod_pkg.sv
verilog/flash_read_if.sv
verilog/key_command_decoder.sv
verilog/address_sequencer.sv
verilog/word_fetcher.sv
verilog/ipod_top.sv
verif/flash_model.sv
verif/tb_ipod.sv

//--- Makefile
# Verilator flow for the sample player

RTL = verilog/ipod_pkg.sv verilog/flash_read_if.sv verilog/key_command_decoder.sv \
      verilog/address_sequencer.sv verilog/word_fetcher.sv verilog/ipod_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --top-module ipod_top $(RTL)

sim:
	verilator --binary --timing --assert --top-module tb_ipod -Mdir obj_dir -f sim.f
	-./obj_dir/Vtb_ipod > sim.log 2>&1
	cat sim.log
	grep -F -q "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log
